// File: verilog.f
verilog/lsq_pkg.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/lsq.sv
testbench/tb_clock_gen.sv
testbench/lsq_assertions.sv
testbench/lsq_tb.sv

// File: Makefile
SIM      := verilator
TOP      := lsq_tb
FILELIST := verilog.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/lsq_tb.sv
`timescale 1ns/1ps

module lsq_tb;

    localparam int LSQ_DEPTH = 8;
    localparam int ROB_IDX_W = 5;
    localparam int PRF_IDX_W = 6;
    localparam int PTR_W     = $clog2(LSQ_DEPTH);
    localparam int MAX_OPS   = 128;
    localparam int SEG1_OPS  = 60;
    localparam int SEG1_EXC  = 40;
    localparam int SEG2_OPS  = 80;
    localparam int TOTAL_OPS = SEG1_OPS + SEG2_OPS;
    localparam logic [PTR_W:0] FULL = (PTR_W+1)'(LSQ_DEPTH);

    logic                        clock;
    logic                        arst_n;
    logic                        except;
    logic                        commit;
    logic                        st_en;
    lsq_pkg::mem_size_e          st_size;
    logic [lsq_pkg::DATA_W-1:0]  st_data;
    logic                        st_data_valid;
    logic [PRF_IDX_W-1:0]        st_prf_idx;
    logic [ROB_IDX_W-1:0]        st_rob_idx;
    logic                        ld_en;
    lsq_pkg::mem_size_e          ld_size;
    logic [ROB_IDX_W-1:0]        ld_rob_idx;
    logic [PRF_IDX_W-1:0]        ld_prf_idx;
    logic                        agen_valid;
    logic                        agen_is_load;
    logic [ROB_IDX_W-1:0]        agen_rob_idx;
    logic [lsq_pkg::ADDR_W-1:0]  agen_addr;
    logic                        cdb_valid;
    logic [PRF_IDX_W-1:0]        cdb_prf_idx;
    logic [lsq_pkg::DATA_W-1:0]  cdb_data;
    logic [lsq_pkg::DATA_W-1:0]  rd_data;
    logic [PTR_W:0]              sq_num_free;
    logic [PTR_W:0]              lq_num_free;
    logic                        wr_en;
    logic [lsq_pkg::ADDR_W-1:0]  wr_addr;
    lsq_pkg::mem_size_e          wr_size;
    logic [lsq_pkg::DATA_W-1:0]  wr_data;
    logic                        rd_en;
    logic [lsq_pkg::ADDR_W-1:0]  rd_addr;
    lsq_pkg::mem_size_e          rd_size;
    logic                        cdb_valid_out;
    logic [lsq_pkg::DATA_W-1:0]  cdb_data_out;
    logic [PRF_IDX_W-1:0]        cdb_prf_idx_out;
    logic [ROB_IDX_W-1:0]        cdb_rob_idx_out;

    // 16-word cache and the byte image the program model runs on
    logic [31:0]                 cache [16];
    logic [7:0]                  ref_mem [64];

    // program in program order
    logic                        op_load [MAX_OPS];
    lsq_pkg::mem_size_e          op_size [MAX_OPS];
    logic [lsq_pkg::ADDR_W-1:0]  op_addr [MAX_OPS];
    logic [31:0]                 op_data [MAX_OPS];
    logic                        op_late [MAX_OPS];
    logic [ROB_IDX_W-1:0]        op_rob [MAX_OPS];
    logic [PRF_IDX_W-1:0]        op_prf [MAX_OPS];
    int                          op_older_lds [MAX_OPS];
    logic                        addr_done [MAX_OPS];
    logic                        data_done [MAX_OPS];

    int seed = 32'hf7070744;
    int n_ops;
    int n_disp;
    int lds_done;
    int addr_q[$];
    int data_q[$];
    int store_q[$];
    int load_q[$];
    int write_q[$];

    tb_clock_gen u_clk (
        .clock(clock),
        .arst_n(arst_n)
    );

    lsq #(
        .LSQ_DEPTH(LSQ_DEPTH),
        .ROB_IDX_W(ROB_IDX_W),
        .PRF_IDX_W(PRF_IDX_W)
    ) u_dut (.*);

    bind lsq lsq_assertions #(
        .LSQ_DEPTH(LSQ_DEPTH),
        .ROB_IDX_W(ROB_IDX_W)
    ) u_assert (.*);

    // cache answers in the same cycle with the aligned word
    assign rd_data = cache[rd_addr[5:2]];

    function automatic int size_bytes(input lsq_pkg::mem_size_e sz);
        case (sz)
            lsq_pkg::size_byte: return 1;
            lsq_pkg::size_half: return 2;
            default:            return 4;
        endcase
    endfunction

    // little endian, zero-extended
    function automatic logic [31:0] model_read(input logic [15:0] a,
                                               input lsq_pkg::mem_size_e sz);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < size_bytes(sz); k++) begin
            v[8*k +: 8] = ref_mem[int'(a[5:0]) + k];
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic set_idle();
        except        = 1'b0;
        commit        = 1'b0;
        st_en         = 1'b0;
        st_size       = lsq_pkg::size_byte;
        st_data       = '0;
        st_data_valid = 1'b0;
        st_prf_idx    = '0;
        st_rob_idx    = '0;
        ld_en         = 1'b0;
        ld_size       = lsq_pkg::size_byte;
        ld_rob_idx    = '0;
        ld_prf_idx    = '0;
        agen_valid    = 1'b0;
        agen_is_load  = 1'b0;
        agen_rob_idx  = '0;
        agen_addr     = '0;
        cdb_valid     = 1'b0;
        cdb_prf_idx   = '0;
        cdb_data      = '0;
    endtask

    // expected load values come from the byte image in program order
    task automatic gen_program(input int n);
        logic [31:0] r;
        logic [3:0]  w;
        int          n_ld;
        int          n_st;
        n_ld = 0;
        n_st = 0;
        for (int b = 0; b < 64; b++) begin
            ref_mem[b] = cache[b / 4][8*(b % 4) +: 8];
        end
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            w = r[6:3];
            op_load[i] = r[0];
            op_size[i] = (r[2:1] == 2'd3) ? lsq_pkg::size_word : lsq_pkg::mem_size_e'(r[2:1]);
            case (op_size[i])
                lsq_pkg::size_byte: op_addr[i] = {10'd0, w, r[8:7]};
                lsq_pkg::size_half: op_addr[i] = {10'd0, w, r[7], 1'b0};
                default:            op_addr[i] = {10'd0, w, 2'b00};
            endcase
            op_late[i]      = r[9];
            op_older_lds[i] = n_ld;
            addr_done[i]    = 1'b0;
            data_done[i]    = 1'b0;
            // rob tags count per queue so they stay unique among live entries
            if (op_load[i]) begin
                op_rob[i]  = ROB_IDX_W'(n_ld);
                op_prf[i]  = PRF_IDX_W'(n_ld);
                op_data[i] = model_read(op_addr[i], op_size[i]);
                n_ld++;
            end else begin
                op_rob[i]  = ROB_IDX_W'(n_st);
                op_prf[i]  = PRF_IDX_W'(n_st + 32);
                op_data[i] = $random(seed);
                for (int k = 0; k < size_bytes(op_size[i]); k++) begin
                    ref_mem[int'(op_addr[i][5:0]) + k] = op_data[i][8*k +: 8];
                end
                n_st++;
            end
        end
    endtask

    task automatic observe();
        int s;
        if (wr_en) begin
            assert (write_q.size() != 0) else report_error("store write with no committed store");
            s = write_q.pop_front();
            assert (wr_addr == op_addr[s] && wr_size == op_size[s] && wr_data == op_data[s])
                else report_error($sformatf("store %0d wrote %h/%0d/%h, expected %h/%0d/%h",
                    s, wr_addr, wr_size, wr_data, op_addr[s], op_size[s], op_data[s]));
            for (int k = 0; k < size_bytes(wr_size); k++) begin
                cache[wr_addr[5:2]][8*(int'(wr_addr[1:0]) + k) +: 8] = wr_data[8*k +: 8];
            end
        end
        assert (write_q.size() == 0) else report_error("no store write one cycle after commit");
        if (cdb_valid_out) begin
            assert (load_q.size() != 0) else report_error("load result with no pending load");
            s = load_q.pop_front();
            assert (cdb_rob_idx_out == op_rob[s] && cdb_prf_idx_out == op_prf[s]
                    && cdb_data_out == op_data[s])
                else report_error($sformatf("load %0d gave rob %0d prf %0d data %h, expected %0d %0d %h",
                    s, cdb_rob_idx_out, cdb_prf_idx_out, cdb_data_out,
                    op_rob[s], op_prf[s], op_data[s]));
            lds_done++;
        end
        // a cache read always belongs to the oldest pending load
        if (rd_en) begin
            assert (load_q.size() != 0) else report_error("cache read with no pending load");
            s = load_q[0];
            assert (rd_addr == op_addr[s] && rd_size == op_size[s])
                else report_error($sformatf("load %0d read %h/%0d, expected %h/%0d",
                    s, rd_addr, rd_size, op_addr[s], op_size[s]));
        end
    endtask

    task automatic drive();
        logic [31:0] r;
        int          k;
        int          s;
        set_idle();
        r = $random(seed);
        // a store commits only once every older load has its result
        if (store_q.size() != 0 && r[1:0] != 2'd0) begin
            s = store_q[0];
            if (addr_done[s] && data_done[s] && lds_done >= op_older_lds[s]) begin
                commit = 1'b1;
                void'(store_q.pop_front());
                write_q.push_back(s);
            end
        end
        if (addr_q.size() != 0 && r[2]) begin
            k = int'(r[15:8]) % addr_q.size();
            s = addr_q[k];
            addr_q.delete(k);
            agen_valid   = 1'b1;
            agen_is_load = op_load[s];
            agen_rob_idx = op_rob[s];
            agen_addr    = op_addr[s];
            addr_done[s] = 1'b1;
        end
        if (data_q.size() != 0 && r[3]) begin
            k = int'(r[23:16]) % data_q.size();
            s = data_q[k];
            data_q.delete(k);
            cdb_valid    = 1'b1;
            cdb_prf_idx  = op_prf[s];
            cdb_data     = op_data[s];
            data_done[s] = 1'b1;
        end
        if (n_disp < n_ops && r[4]) begin
            s = n_disp;
            if (op_load[s] && lq_num_free != '0) begin
                ld_en      = 1'b1;
                ld_size    = op_size[s];
                ld_rob_idx = op_rob[s];
                ld_prf_idx = op_prf[s];
                load_q.push_back(s);
                addr_q.push_back(s);
                n_disp++;
            end else if (!op_load[s] && sq_num_free != '0) begin
                st_en         = 1'b1;
                st_size       = op_size[s];
                st_data       = op_late[s] ? ~op_data[s] : op_data[s];
                st_data_valid = !op_late[s];
                st_prf_idx    = op_prf[s];
                st_rob_idx    = op_rob[s];
                store_q.push_back(s);
                addr_q.push_back(s);
                // producer may broadcast in the dispatch cycle itself
                if (op_late[s] && !cdb_valid && r[5]) begin
                    cdb_valid    = 1'b1;
                    cdb_prf_idx  = op_prf[s];
                    cdb_data     = op_data[s];
                    data_done[s] = 1'b1;
                end else if (op_late[s]) begin
                    data_q.push_back(s);
                end else begin
                    data_done[s] = 1'b1;
                end
                n_disp++;
            end
        end
    endtask

    task automatic flush();
        set_idle();
        except = 1'b1;
        @(negedge clock);
        except = 1'b0;
        assert (sq_num_free == FULL && lq_num_free == FULL)
            else report_error($sformatf("free counts %0d %0d after except", sq_num_free, lq_num_free));
        assert (!wr_en && !rd_en && !cdb_valid_out) else report_error("strobe active after except");
        addr_q.delete();
        data_q.delete();
        store_q.delete();
        load_q.delete();
        // flushed entries must stay silent
        repeat (4) begin
            @(negedge clock);
            observe();
        end
    endtask

    task automatic run_segment(input int n, input int exc_at);
        gen_program(n);
        n_ops    = n;
        n_disp   = 0;
        lds_done = 0;
        while (!(n_disp == n_ops && load_q.size() == 0 && store_q.size() == 0
                 && write_q.size() == 0)) begin
            @(negedge clock);
            observe();
            if (exc_at >= 0 && n_disp >= exc_at) begin
                flush();
                return;
            end
            drive();
        end
        set_idle();
    endtask

    initial begin
        set_idle();
        for (int w = 0; w < 16; w++) begin
            cache[w] = 32'(w + 1) * 32'h9e3779b9;
        end
        @(posedge arst_n);
        @(negedge clock);
        assert (sq_num_free == FULL && lq_num_free == FULL)
            else report_error("free counts not full after reset");
        assert (!wr_en && !rd_en && !cdb_valid_out) else report_error("strobe active after reset");
        run_segment(SEG1_OPS, SEG1_EXC);
        run_segment(SEG2_OPS, -1);
        // nothing may come out once the program has drained
        repeat (4) begin
            @(negedge clock);
            observe();
        end
        if (u_dut.u_assert.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", u_dut.u_assert.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures");
        end
    end

    // watchdog, 200 cycles per operation plus reset
    initial begin
        repeat (TOTAL_OPS * 200 + 32) @(posedge clock);
        $display("watchdog expired: loads or stores never completed, the run hung");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

// File: testbench/lsq_assertions.sv
`timescale 1ns/1ps

module lsq_assertions #(
    parameter int LSQ_DEPTH = 8,
    parameter int ROB_IDX_W = 5,
    localparam int PTR_W    = $clog2(LSQ_DEPTH)
) (
    input logic                 clock,
    input logic                 arst_n,
    input logic                 except,
    input logic                 st_en,
    input logic                 ld_en,
    input logic [PTR_W:0]       sq_num_free,
    input logic [PTR_W:0]       lq_num_free,
    input logic                 wr_en,
    input logic                 cdb_valid_out,
    input logic [ROB_IDX_W-1:0] cdb_rob_idx_out
);

    localparam logic [PTR_W:0] FULL = (PTR_W+1)'(LSQ_DEPTH);

    int fail_count = 0;

    a_free_max: assert property (@(posedge clock) disable iff (!arst_n)
        (sq_num_free <= FULL) && (lq_num_free <= FULL))
        else begin
            $error("free count above queue depth");
            fail_count++;
        end

    a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
        (!st_en || (sq_num_free != '0)) && (!ld_en || (lq_num_free != '0)))
        else begin
            $error("dispatch into a full queue");
            fail_count++;
        end

    // one result per load
    a_result_once: assert property (@(posedge clock) disable iff (!arst_n)
        cdb_valid_out |=> !(cdb_valid_out && (cdb_rob_idx_out == $past(cdb_rob_idx_out))))
        else begin
            $error("load result repeated for one rob index");
            fail_count++;
        end

    a_flush_write: assert property (@(posedge clock) disable iff (!arst_n)
        except |=> !wr_en)
        else begin
            $error("cache write in the cycle after except");
            fail_count++;
        end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// File: verilog/lsq.sv
`timescale 1ns/1ps

module lsq #(
    parameter int LSQ_DEPTH = 8,
    parameter int ROB_IDX_W = 5,
    parameter int PRF_IDX_W = 6,
    localparam int PTR_W    = $clog2(LSQ_DEPTH)
) (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        except,
    input  logic                        commit,
    input  logic                        st_en,
    input  lsq_pkg::mem_size_e          st_size,
    input  logic [lsq_pkg::DATA_W-1:0]  st_data,
    input  logic                        st_data_valid,
    input  logic [PRF_IDX_W-1:0]        st_prf_idx,
    input  logic [ROB_IDX_W-1:0]        st_rob_idx,
    input  logic                        ld_en,
    input  lsq_pkg::mem_size_e          ld_size,
    input  logic [ROB_IDX_W-1:0]        ld_rob_idx,
    input  logic [PRF_IDX_W-1:0]        ld_prf_idx,
    input  logic                        agen_valid,
    input  logic                        agen_is_load,
    input  logic [ROB_IDX_W-1:0]        agen_rob_idx,
    input  logic [lsq_pkg::ADDR_W-1:0]  agen_addr,
    input  logic                        cdb_valid,
    input  logic [PRF_IDX_W-1:0]        cdb_prf_idx,
    input  logic [lsq_pkg::DATA_W-1:0]  cdb_data,
    input  logic [lsq_pkg::DATA_W-1:0]  rd_data,
    output logic [PTR_W:0]              sq_num_free,
    output logic [PTR_W:0]              lq_num_free,
    output logic                        wr_en,
    output logic [lsq_pkg::ADDR_W-1:0]  wr_addr,
    output lsq_pkg::mem_size_e          wr_size,
    output logic [lsq_pkg::DATA_W-1:0]  wr_data,
    output logic                        rd_en,
    output logic [lsq_pkg::ADDR_W-1:0]  rd_addr,
    output lsq_pkg::mem_size_e          rd_size,
    output logic                        cdb_valid_out,
    output logic [lsq_pkg::DATA_W-1:0]  cdb_data_out,
    output logic [PRF_IDX_W-1:0]        cdb_prf_idx_out,
    output logic [ROB_IDX_W-1:0]        cdb_rob_idx_out
);

    // store queue state seen by the load queue
    logic [PTR_W:0]                        sq_head;
    logic [PTR_W:0]                        sq_tail;
    logic [LSQ_DEPTH-1:0]                  sq_valid;
    logic [LSQ_DEPTH*lsq_pkg::ADDR_W-1:0]  sq_addr;
    logic [LSQ_DEPTH-1:0]                  sq_addr_valid;
    logic [2*LSQ_DEPTH-1:0]                sq_size;
    logic [LSQ_DEPTH*lsq_pkg::DATA_W-1:0]  sq_data;
    logic [LSQ_DEPTH-1:0]                  sq_data_valid;

    // port names match the signals here one to one
    store_queue #(
        .LSQ_DEPTH(LSQ_DEPTH),
        .ROB_IDX_W(ROB_IDX_W),
        .PRF_IDX_W(PRF_IDX_W)
    ) u_sq (.*);

    load_queue #(
        .LSQ_DEPTH(LSQ_DEPTH),
        .ROB_IDX_W(ROB_IDX_W),
        .PRF_IDX_W(PRF_IDX_W)
    ) u_lq (.*);

endmodule

// File: verilog/load_queue.sv
`timescale 1ns/1ps

module load_queue #(
    parameter int LSQ_DEPTH = 8,
    parameter int ROB_IDX_W = 5,
    parameter int PRF_IDX_W = 6,
    localparam int PTR_W    = $clog2(LSQ_DEPTH)
) (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  except,
    input  logic                                  ld_en,
    input  lsq_pkg::mem_size_e                    ld_size,
    input  logic [ROB_IDX_W-1:0]                  ld_rob_idx,
    input  logic [PRF_IDX_W-1:0]                  ld_prf_idx,
    input  logic                                  agen_valid,
    input  logic                                  agen_is_load,
    input  logic [ROB_IDX_W-1:0]                  agen_rob_idx,
    input  logic [lsq_pkg::ADDR_W-1:0]            agen_addr,
    input  logic [PTR_W:0]                        sq_head,
    input  logic [PTR_W:0]                        sq_tail,
    input  logic [LSQ_DEPTH-1:0]                  sq_valid,
    input  logic [LSQ_DEPTH*lsq_pkg::ADDR_W-1:0]  sq_addr,
    input  logic [LSQ_DEPTH-1:0]                  sq_addr_valid,
    input  logic [2*LSQ_DEPTH-1:0]                sq_size,
    input  logic [LSQ_DEPTH*lsq_pkg::DATA_W-1:0]  sq_data,
    input  logic [LSQ_DEPTH-1:0]                  sq_data_valid,
    input  logic [lsq_pkg::DATA_W-1:0]            rd_data,
    output logic                                  rd_en,
    output logic [lsq_pkg::ADDR_W-1:0]            rd_addr,
    output lsq_pkg::mem_size_e                    rd_size,
    output logic                                  cdb_valid_out,
    output logic [lsq_pkg::DATA_W-1:0]            cdb_data_out,
    output logic [PRF_IDX_W-1:0]                  cdb_prf_idx_out,
    output logic [ROB_IDX_W-1:0]                  cdb_rob_idx_out,
    output logic [PTR_W:0]                        lq_num_free
);

    logic [PTR_W:0]                              lq_head;
    logic [PTR_W:0]                              lq_tail;
    logic [PTR_W-1:0]                            head_idx;
    logic [PTR_W-1:0]                            tail_idx;
    logic [LSQ_DEPTH-1:0]                        valid;
    logic [LSQ_DEPTH-1:0]                        agen_hit;
    lsq_pkg::lq_state_e [LSQ_DEPTH-1:0]          state;
    lsq_pkg::mem_size_e [LSQ_DEPTH-1:0]          size;
    logic [LSQ_DEPTH-1:0][lsq_pkg::ADDR_W-1:0]   addr;
    logic [LSQ_DEPTH-1:0][ROB_IDX_W-1:0]         rob;
    logic [LSQ_DEPTH-1:0][PRF_IDX_W-1:0]         prf;
    logic [LSQ_DEPTH-1:0][PTR_W:0]               snap;
    logic [PTR_W:0]                              older_cnt;
    logic                                        addr_wait;
    logic                                        hit;
    logic [PTR_W-1:0]                            hit_idx;
    logic                                        fwd_ok;
    lsq_pkg::lq_state_e                          head_state;
    logic                                        fire;
    logic [lsq_pkg::DATA_W-1:0]                  result;

    function automatic logic [lsq_pkg::DATA_W-1:0] size_mask(
        input logic [lsq_pkg::DATA_W-1:0] value,
        input lsq_pkg::mem_size_e         sz
    );
        case (sz)
            lsq_pkg::size_byte: return {{(lsq_pkg::DATA_W-8){1'b0}}, value[7:0]};
            lsq_pkg::size_half: return {{(lsq_pkg::DATA_W-16){1'b0}}, value[15:0]};
            default:            return value;
        endcase
    endfunction

    assign head_idx    = lq_head[PTR_W-1:0];
    assign tail_idx    = lq_tail[PTR_W-1:0];
    assign lq_num_free = (PTR_W+1)'(LSQ_DEPTH) - (lq_tail - lq_head);

    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            agen_hit[i] = agen_valid && agen_is_load && valid[i]
                          && (state[i] == lsq_pkg::lq_wait_addr) && (rob[i] == agen_rob_idx);
        end
    end

    // walk the older stores from sq_head, the last word match is the youngest
    always_comb begin
        logic [PTR_W-1:0] idx;
        older_cnt = snap[head_idx] - sq_head;
        addr_wait = 1'b0;
        hit       = 1'b0;
        hit_idx   = '0;
        for (int k = 0; k < LSQ_DEPTH; k++) begin
            idx = sq_head[PTR_W-1:0] + PTR_W'(k);
            if (((PTR_W+1)'(k) < older_cnt) && sq_valid[idx]) begin
                if (!sq_addr_valid[idx]) begin
                    addr_wait = 1'b1;
                end else if (sq_addr[idx*lsq_pkg::ADDR_W+2 +: lsq_pkg::ADDR_W-2]
                             == addr[head_idx][lsq_pkg::ADDR_W-1:2]) begin
                    hit     = 1'b1;
                    hit_idx = idx;
                end
            end
        end
    end

    // exact match only, partial overlaps wait for the store to commit
    assign fwd_ok = hit && sq_data_valid[hit_idx]
                    && (sq_addr[hit_idx*lsq_pkg::ADDR_W +: lsq_pkg::ADDR_W] == addr[head_idx])
                    && (sq_size[hit_idx*2 +: 2] == size[head_idx]);

    always_comb begin
        if (state[head_idx] == lsq_pkg::lq_wait_addr) begin
            head_state = lsq_pkg::lq_wait_addr;
        end else if (addr_wait || (hit && !fwd_ok)) begin
            head_state = lsq_pkg::lq_wait_store;
        end else begin
            head_state = lsq_pkg::lq_ready;
        end
    end

    assign fire    = valid[head_idx] && (head_state == lsq_pkg::lq_ready);
    assign rd_en   = fire && !hit;
    assign rd_addr = addr[head_idx];
    assign rd_size = size[head_idx];

    // cache returns the aligned word, little endian
    assign result = hit ? size_mask(sq_data[hit_idx*lsq_pkg::DATA_W +: lsq_pkg::DATA_W],
                                    size[head_idx])
                        : size_mask(rd_data >> {rd_addr[1:0], 3'b000}, size[head_idx]);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lq_head       <= '0;
            lq_tail       <= '0;
            valid         <= '0;
            cdb_valid_out <= 1'b0;
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                state[i] <= lsq_pkg::lq_wait_addr;
            end
        end else if (except) begin
            lq_head       <= '0;
            lq_tail       <= '0;
            valid         <= '0;
            cdb_valid_out <= 1'b0;
        end else begin
            cdb_valid_out <= fire;
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (agen_hit[i]) begin
                    state[i] <= lsq_pkg::lq_wait_store;
                end
            end
            if (fire) begin
                valid[head_idx] <= 1'b0;
                lq_head         <= lq_head + 1'b1;
            end
            if (ld_en) begin
                valid[tail_idx] <= 1'b1;
                state[tail_idx] <= lsq_pkg::lq_wait_addr;
                lq_tail         <= lq_tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (agen_hit[i]) begin
                addr[i] <= agen_addr;
            end
        end
        // a store dispatched in the same cycle counts as younger
        if (ld_en) begin
            size[tail_idx] <= ld_size;
            rob[tail_idx]  <= ld_rob_idx;
            prf[tail_idx]  <= ld_prf_idx;
            snap[tail_idx] <= sq_tail;
        end
        if (fire) begin
            cdb_data_out    <= result;
            cdb_prf_idx_out <= prf[head_idx];
            cdb_rob_idx_out <= rob[head_idx];
        end
    end

endmodule

// File: verilog/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
    parameter int LSQ_DEPTH = 8,
    parameter int ROB_IDX_W = 5,
    parameter int PRF_IDX_W = 6,
    localparam int PTR_W    = $clog2(LSQ_DEPTH)
) (
    input  logic                                  clock,
    input  logic                                  arst_n,
    input  logic                                  except,
    input  logic                                  commit,
    input  logic                                  st_en,
    input  lsq_pkg::mem_size_e                    st_size,
    input  logic [lsq_pkg::DATA_W-1:0]            st_data,
    input  logic                                  st_data_valid,
    input  logic [PRF_IDX_W-1:0]                  st_prf_idx,
    input  logic [ROB_IDX_W-1:0]                  st_rob_idx,
    input  logic                                  agen_valid,
    input  logic                                  agen_is_load,
    input  logic [ROB_IDX_W-1:0]                  agen_rob_idx,
    input  logic [lsq_pkg::ADDR_W-1:0]            agen_addr,
    input  logic                                  cdb_valid,
    input  logic [PRF_IDX_W-1:0]                  cdb_prf_idx,
    input  logic [lsq_pkg::DATA_W-1:0]            cdb_data,
    output logic [PTR_W:0]                        sq_head,
    output logic [PTR_W:0]                        sq_tail,
    output logic [LSQ_DEPTH-1:0]                  sq_valid,
    output logic [LSQ_DEPTH*lsq_pkg::ADDR_W-1:0]  sq_addr,
    output logic [LSQ_DEPTH-1:0]                  sq_addr_valid,
    output logic [2*LSQ_DEPTH-1:0]                sq_size,
    output logic [LSQ_DEPTH*lsq_pkg::DATA_W-1:0]  sq_data,
    output logic [LSQ_DEPTH-1:0]                  sq_data_valid,
    output logic                                  wr_en,
    output logic [lsq_pkg::ADDR_W-1:0]            wr_addr,
    output lsq_pkg::mem_size_e                    wr_size,
    output logic [lsq_pkg::DATA_W-1:0]            wr_data,
    output logic [PTR_W:0]                        sq_num_free
);

    logic [PTR_W-1:0]                            head_idx;
    logic [PTR_W-1:0]                            tail_idx;
    logic [LSQ_DEPTH-1:0]                        valid;
    logic [LSQ_DEPTH-1:0]                        addr_valid;
    logic [LSQ_DEPTH-1:0]                        data_valid;
    logic [LSQ_DEPTH-1:0]                        addr_hit;
    logic [LSQ_DEPTH-1:0]                        data_hit;
    logic                                        disp_fill;
    lsq_pkg::mem_size_e [LSQ_DEPTH-1:0]          size;
    logic [LSQ_DEPTH-1:0][lsq_pkg::ADDR_W-1:0]   addr;
    logic [LSQ_DEPTH-1:0][lsq_pkg::DATA_W-1:0]   data;
    logic [LSQ_DEPTH-1:0][ROB_IDX_W-1:0]         rob;
    logic [LSQ_DEPTH-1:0][PRF_IDX_W-1:0]         prf;

    // pointers carry a wrap bit, so tail - head is the occupancy
    assign head_idx    = sq_head[PTR_W-1:0];
    assign tail_idx    = sq_tail[PTR_W-1:0];
    assign sq_num_free = (PTR_W+1)'(LSQ_DEPTH) - (sq_tail - sq_head);

    // producer broadcasting in the same cycle as dispatch
    assign disp_fill = cdb_valid && !st_data_valid && (cdb_prf_idx == st_prf_idx);

    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            addr_hit[i] = agen_valid && !agen_is_load && valid[i] && (rob[i] == agen_rob_idx);
            data_hit[i] = cdb_valid && valid[i] && !data_valid[i] && (prf[i] == cdb_prf_idx);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sq_head    <= '0;
            sq_tail    <= '0;
            valid      <= '0;
            addr_valid <= '0;
            data_valid <= '0;
            wr_en      <= 1'b0;
        end else if (except) begin
            sq_head    <= '0;
            sq_tail    <= '0;
            valid      <= '0;
            addr_valid <= '0;
            data_valid <= '0;
            wr_en      <= 1'b0;
        end else begin
            wr_en <= commit;
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (addr_hit[i]) begin
                    addr_valid[i] <= 1'b1;
                end
                if (data_hit[i]) begin
                    data_valid[i] <= 1'b1;
                end
            end
            if (commit) begin
                valid[head_idx] <= 1'b0;
                sq_head         <= sq_head + 1'b1;
            end
            // after commit so a full queue can reuse the freed slot
            if (st_en) begin
                valid[tail_idx]      <= 1'b1;
                addr_valid[tail_idx] <= 1'b0;
                data_valid[tail_idx] <= st_data_valid || disp_fill;
                sq_tail              <= sq_tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (addr_hit[i]) begin
                addr[i] <= agen_addr;
            end
            if (data_hit[i]) begin
                data[i] <= cdb_data;
            end
        end
        if (st_en) begin
            size[tail_idx] <= st_size;
            data[tail_idx] <= st_data_valid ? st_data : cdb_data;
            rob[tail_idx]  <= st_rob_idx;
            prf[tail_idx]  <= st_prf_idx;
        end
        if (commit) begin
            wr_addr <= addr[head_idx];
            wr_size <= size[head_idx];
            wr_data <= data[head_idx];
        end
    end

    assign sq_valid      = valid;
    assign sq_addr       = addr;
    assign sq_addr_valid = addr_valid;
    assign sq_size       = size;
    assign sq_data       = data;
    assign sq_data_valid = data_valid;

endmodule

// File: verilog/lsq_pkg.sv
package lsq_pkg;

    // byte address and data widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // load entry progress
    typedef enum logic [1:0] {
        lq_wait_addr  = 2'd0,
        lq_wait_store = 2'd1,
        lq_ready      = 2'd2
    } lq_state_e;

endpackage
